// ==== px_state_pkg.sv ====
/*
	Processor state definitions
	One-hot state indices, the state vector type and state class sets
*/
`default_nettype none

package px_state_pkg;

	localparam int n_states = 21;	// State flip-flops in total

	typedef logic [n_states-1:0] state_vec_t;

	// Main cycle states
	localparam int st_p0 = 0;	// Start / fetch
	localparam int st_p1 = 1;
	localparam int st_p2 = 2;
	localparam int st_p3 = 3;
	localparam int st_p4 = 4;
	localparam int st_p5 = 5;
	localparam int st_k1 = 6;	// Instruction word read
	localparam int st_k2 = 7;
	localparam int st_wa = 8;
	localparam int st_wp = 9;
	localparam int st_we = 10;
	localparam int st_wr = 11;	// Operand read
	localparam int st_wz = 12;
	localparam int st_wx = 13;
	localparam int st_wm = 14;	// Memory write
	localparam int st_ww = 15;	// Result write
	// Interrupt entry states, kept contiguous
	localparam int st_i1 = 16;
	localparam int st_i2 = 17;
	localparam int st_i3 = 18;
	localparam int st_i4 = 19;
	localparam int st_i5 = 20;

	localparam state_vec_t bus_read_set = (state_vec_t'(1) << st_k1) | (state_vec_t'(1) << st_p1)
		| (state_vec_t'(1) << st_wr) | (state_vec_t'(1) << st_i3) | (state_vec_t'(1) << st_i5);
	localparam state_vec_t bus_write_set = (state_vec_t'(1) << st_ww) | (state_vec_t'(1) << st_wm)
		| (state_vec_t'(1) << st_i2) | (state_vec_t'(1) << st_i4);
	localparam state_vec_t long_set = (state_vec_t'(1) << st_k2) | (state_vec_t'(1) << st_p0)
		| (state_vec_t'(1) << st_i1);	// Non-bus states with long wait
	localparam state_vec_t reset_state = state_vec_t'(1) << st_p0;	// Only P0 after clear

endpackage

`default_nettype wire

// ==== px_timing_pkg.sv ====
/*
	Cycle timing constants
	Strobe widths, wait lengths and bus timeout, all in got cycles
*/
`default_nettype none

package px_timing_pkg;

	// Strobe one-shot widths
	localparam int strob1_ticks = 3;
	localparam int strob2_ticks = 2;

	// Gap between strob1 and strob2
	localparam int short_wait = 2;	// Short non-bus states, also bus minimum
	localparam int long_wait = 5;	// States in long_set

	// System bus answer supervision
	localparam int alarm_ticks = 40;	// Granted cycles without answer
	localparam int alarm_pulse_ticks = 3;	// Width of the alarm pulse

	// No-memory answer stops the processor
	localparam bit stop_on_nomem = 1'b1;

endpackage

`default_nettype wire

// ==== one_shot.sv ====
/*
	Retriggerable one-shot
	Holds pulse high for width cycles after each rising edge of trig
*/
`timescale 1ns/1ns
`default_nettype none

module one_shot #(
	parameter int width = 3	// Pulse width in got cycles
) (
	input wire logic got,
	input wire logic clo_,
	input wire logic trig,	// Level, rising edge starts the pulse
	output logic pulse
);

	localparam int cnt_w = $clog2(width + 1);

	logic trig_q;	// Previous trig for edge detect
	logic [cnt_w-1:0] cnt;	// Remaining pulse cycles

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			trig_q <= 1'b0;
			cnt <= '0;
		end else begin
			trig_q <= trig;
			if (trig && !trig_q)
				cnt <= cnt_w'(width);	// Fresh rise reloads, even mid-pulse
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
		end
	end

	assign pulse = (cnt != '0);

endmodule

`default_nettype wire

// ==== delay_line.sv ====
/*
	Level delay line
	Shift register that delays a single bit by depth got cycles
*/
`timescale 1ns/1ns
`default_nettype none

module delay_line #(
	parameter int depth = 2	// Delay in got cycles, at least 1
) (
	input wire logic got,
	input wire logic clo_,
	input wire logic din,
	output logic dout
);

	logic [depth-1:0] taps;	// taps[0] is the newest sample

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			taps <= '0;
		end else begin
			taps[0] <= din;
			for (int i = 1; i < depth; i++)
				taps[i] <= taps[i-1];	// Shift toward the output
		end
	end

	assign dout = taps[depth-1];

endmodule

`default_nettype wire

// ==== state_register.sv ====
/*
	Processor state register
	One-hot state flip-flops loaded with the enter vector on each advance
*/
`timescale 1ns/1ns
`default_nettype none

module state_register (
	input wire logic got,
	input wire logic clo_,	// Clear presets P0
	input wire logic advance,	// One-cycle end of processor cycle
	input wire px_state_pkg::state_vec_t enter,	// Main state enter requests
	input wire logic [4:0] int_enter,	// I1..I5 enter, bit 0 is I1
	output px_state_pkg::state_vec_t state
);

	px_state_pkg::state_vec_t nxt;	// Merged enter vector

	// Interrupt bits are owned by the interrupt phase logic,
	// whatever the environment puts on those enter lines
	always_comb begin
		nxt = enter;
		nxt[px_state_pkg::st_i1] = int_enter[0];
		nxt[px_state_pkg::st_i2] = int_enter[1];
		nxt[px_state_pkg::st_i3] = int_enter[2];
		nxt[px_state_pkg::st_i4] = int_enter[3];
		nxt[px_state_pkg::st_i5] = int_enter[4];
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_)
			state <= px_state_pkg::reset_state;	// Set input of P0
		else if (advance)
			state <= nxt;	// All states change at once
	end

endmodule

`default_nettype wire

// ==== strobe_gen.sv ====
/*
	Cycle strobe generator
	Times strob1, wait, strob2 and advance for each processor cycle
	Bus cycles wait for bus_done, single step holds strob1 for a step pulse
*/
`timescale 1ns/1ns
`default_nettype none

module strobe_gen (
	input wire logic got,
	input wire logic clo_,
	input wire px_state_pkg::state_vec_t state,
	input wire logic bus_done,	// End of bus transfer
	input wire logic step_mode,	// Single-cycle operation
	input wire logic step,	// One-cycle step request
	output logic strob1,
	output logic strob2,
	output logic advance
);

	localparam int cnt_w = $clog2(px_timing_pkg::long_wait + px_timing_pkg::strob1_ticks
		+ px_timing_pkg::strob2_ticks);

	typedef enum logic [2:0] {ph_hold, ph_s1, ph_wait, ph_s2, ph_adv} phase_t;

	phase_t ph;	// Cycle phase
	logic [cnt_w-1:0] cnt;	// Phase length counter
	logic [cnt_w-1:0] wait_len;	// Gap for the current state
	logic is_bus, is_long;	// Class of the current state
	logic go;	// Next cycle may start
	logic launch;	// Starts strob1
	logic fire2;	// Starts strob2
	logic step_armed;	// Step hold flip-flop

	assign is_bus = |(state & (px_state_pkg::bus_read_set | px_state_pkg::bus_write_set));
	assign is_long = |(state & px_state_pkg::long_set);
	assign wait_len = is_long ? cnt_w'(px_timing_pkg::long_wait) : cnt_w'(px_timing_pkg::short_wait);

	assign go = !step_mode || step_armed;
	assign launch = go && (ph == ph_hold || ph == ph_adv);	// Strob1 right after advance
	assign fire2 = (ph == ph_wait) && (cnt == '0) && (!is_bus || bus_done);
	assign advance = (ph == ph_adv);

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			ph <= ph_hold;
			cnt <= '0;
			step_armed <= 1'b0;
		end else begin
			step_armed <= step || (step_armed && !launch);	// Used up by one cycle
			case (ph)
				ph_hold, ph_adv: begin
					if (launch) begin
						ph <= ph_s1;
						cnt <= cnt_w'(px_timing_pkg::strob1_ticks - 1);
					end else begin
						ph <= ph_hold;	// Wait for step
					end
				end
				ph_s1: begin
					if (cnt == '0) begin
						ph <= ph_wait;
						cnt <= wait_len - 1'b1;	// New state is valid by now
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				ph_wait: begin
					if (fire2) begin
						ph <= ph_s2;
						cnt <= cnt_w'(px_timing_pkg::strob2_ticks - 1);
					end else if (cnt != '0) begin
						cnt <= cnt - 1'b1;	// Bus cycles park at zero
					end
				end
				ph_s2: begin
					if (cnt == '0)
						ph <= ph_adv;
					else
						cnt <= cnt - 1'b1;
				end
				default: ph <= ph_hold;
			endcase
		end
	end

	one_shot #(.width(px_timing_pkg::strob1_ticks)) u_strob1 (
		.got(got),
		.clo_(clo_),
		.trig(launch),
		.pulse(strob1)
	);

	one_shot #(.width(px_timing_pkg::strob2_ticks)) u_strob2 (
		.got(got),
		.clo_(clo_),
		.trig(fire2),
		.pulse(strob2)
	);

endmodule

`default_nettype wire

// ==== interrupt_phase.sv ====
/*
	Interrupt phase control
	Entry decode for I1..I5 and end of interrupt sequence flag
*/
`timescale 1ns/1ns
`default_nettype none

module interrupt_phase (
	input wire logic got,
	input wire logic clo_,
	input wire px_state_pkg::state_vec_t state,
	input wire logic int_start,	// Interrupt request accepted
	input wire logic lip,	// Return from interrupt
	output logic [4:0] int_enter,	// I1..I5 enter, bit 0 is I1
	output logic ekc_i	// End of interrupt cycle
);

	logic i1, i2, i3, i4, i5;
	logic in_int;	// Any I state active
	logic ret_path;	// Short path I1, I3, I5

	assign i1 = state[px_state_pkg::st_i1];
	assign i2 = state[px_state_pkg::st_i2];
	assign i3 = state[px_state_pkg::st_i3];
	assign i4 = state[px_state_pkg::st_i4];
	assign i5 = state[px_state_pkg::st_i5];
	assign in_int = i1 | i2 | i3 | i4 | i5;

	// Path choice frozen once I1 is loaded
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_)
			ret_path <= 1'b0;
		else if (!in_int)
			ret_path <= lip;
	end

	assign int_enter[0] = int_start && !in_int;	// New sequence only
	assign int_enter[1] = i1 && !ret_path;
	assign int_enter[2] = (i1 && ret_path) || i2;
	assign int_enter[3] = i3 && !ret_path;
	assign int_enter[4] = (i3 && ret_path) || i4;

	assign ekc_i = i5;	// Environment takes over after I5

endmodule

`default_nettype wire

// ==== bus_request.sv ====
/*
	System bus request control
	Request, drivers, answer handling and alarm timeout
	Holds the fault and halt latches
*/
`timescale 1ns/1ns
`default_nettype none

module bus_request (
	input wire logic got,
	input wire logic clo_,
	input wire px_state_pkg::state_vec_t state,
	input wire logic strob1,
	input wire logic bus_grant,	// Bus given to the processor
	input wire logic rok_,	// Answer OK
	input wire logic ren_,	// Answer no memory
	input wire logic stop_,	// Clears fault and halt
	output logic zg,	// Bus request
	output logic dr_,	// Read driver
	output logic dw_,	// Write driver
	output logic ok,
	output logic no_mem,
	output logic bus_done,
	output logic alarm,
	output logic awaria,	// Fault latch
	output logic hlt	// Halt latch
);

	localparam int tmr_w = $clog2(px_timing_pkg::alarm_ticks);

	logic is_rd, is_wr;	// Bus class of state
	logic strob1_q;	// For strob1 falling edge
	logic granted;	// Request active and granted
	logic ans_ok, ans_nm, answered;
	logic tmo, tmo_d;	// Timeout and its aligned copy
	logic done_ans;	// Registered answer end
	logic [tmr_w-1:0] tmr;	// Granted cycles since request

	assign is_rd = |(state & px_state_pkg::bus_read_set);
	assign is_wr = |(state & px_state_pkg::bus_write_set);
	assign granted = zg && bus_grant;

	assign ans_ok = granted && !rok_;
	assign ans_nm = granted && !ren_ && rok_;	// OK wins over no memory
	assign answered = ans_ok || ans_nm;
	assign tmo = granted && !answered && (tmr == tmr_w'(px_timing_pkg::alarm_ticks - 1));

	assign dr_ = !(granted && is_rd);	// Idle while grant is low
	assign dw_ = !(granted && is_wr);
	assign bus_done = done_ans || tmo_d;

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			strob1_q <= 1'b0;
			zg <= 1'b0;
			tmr <= '0;
			ok <= 1'b0;
			no_mem <= 1'b0;
			done_ans <= 1'b0;
			awaria <= 1'b0;
			hlt <= 1'b0;
		end else begin
			strob1_q <= strob1;
			if (strob1_q && !strob1 && (is_rd || is_wr))
				zg <= 1'b1;	// Request at end of strob1
			else if (answered || tmo)
				zg <= 1'b0;
			if (!zg)
				tmr <= '0;
			else if (bus_grant)
				tmr <= tmr + 1'b1;	// Only granted cycles count
			ok <= answered;
			no_mem <= ans_nm;
			done_ans <= answered;
			if (!stop_)
				awaria <= 1'b0;
			else if (tmo_d)
				awaria <= 1'b1;
			if (!stop_)
				hlt <= 1'b0;
			else if (ans_nm && px_timing_pkg::stop_on_nomem)
				hlt <= 1'b1;
		end
	end

	// Timeout registered once, so alarm follows bus_done
	delay_line #(.depth(1)) u_tmo_dly (
		.got(got),
		.clo_(clo_),
		.din(tmo),
		.dout(tmo_d)
	);

	one_shot #(.width(px_timing_pkg::alarm_pulse_ticks)) u_alarm (
		.got(got),
		.clo_(clo_),
		.trig(tmo_d),
		.pulse(alarm)
	);

endmodule

`default_nettype wire

// ==== state_control.sv ====
/*
	Processor state control block
	State register, cycle strobes, interrupt entry and system bus control
*/
`timescale 1ns/1ns
`default_nettype none

module state_control (
	input wire logic got,	// Free-running clock
	input wire logic clo_,	// General clear
	input wire px_state_pkg::state_vec_t enter,	// Main state enter requests
	input wire logic int_start,
	input wire logic lip,
	input wire logic step_mode,
	input wire logic step,
	input wire logic bus_grant,
	input wire logic rok_,
	input wire logic ren_,
	input wire logic stop_,
	output px_state_pkg::state_vec_t state,
	output logic strob1,
	output logic strob2,
	output logic advance,
	output logic zg,
	output logic dr_,
	output logic dw_,
	output logic ok,
	output logic no_mem,
	output logic alarm,
	output logic awaria,
	output logic hlt,
	output logic ekc_i
);

	logic [4:0] int_enter;	// I1..I5 entries
	logic bus_done;	// Bus transfer finished

	state_register u_state (
		.got(got),
		.clo_(clo_),
		.advance(advance),
		.enter(enter),
		.int_enter(int_enter),
		.state(state)
	);

	strobe_gen u_strobe (
		.got(got),
		.clo_(clo_),
		.state(state),
		.bus_done(bus_done),
		.step_mode(step_mode),
		.step(step),
		.strob1(strob1),
		.strob2(strob2),
		.advance(advance)
	);

	interrupt_phase u_int (
		.got(got),
		.clo_(clo_),
		.state(state),
		.int_start(int_start),
		.lip(lip),
		.int_enter(int_enter),
		.ekc_i(ekc_i)
	);

	bus_request u_bus (
		.got(got),
		.clo_(clo_),
		.state(state),
		.strob1(strob1),
		.bus_grant(bus_grant),
		.rok_(rok_),
		.ren_(ren_),
		.stop_(stop_),
		.zg(zg),
		.dr_(dr_),
		.dw_(dw_),
		.ok(ok),
		.no_mem(no_mem),
		.bus_done(bus_done),
		.alarm(alarm),
		.awaria(awaria),
		.hlt(hlt)
	);

endmodule

`default_nettype wire

// ==== tb_state_control.sv ====
/*
	Testbench for the processor state control block
	Directed tests of cycle timing, bus transfers, faults and interrupt paths
*/
`timescale 1ns/1ns
`default_nettype none

module tb_state_control;

	localparam int resp_ok = 0;	// Answer with rok_
	localparam int resp_nomem = 1;	// Answer with ren_
	localparam int resp_silent = 2;	// No answer at all
	localparam int long_len = px_timing_pkg::strob1_ticks + px_timing_pkg::long_wait
		+ px_timing_pkg::strob2_ticks + 1;
	localparam int short_len = px_timing_pkg::strob1_ticks + px_timing_pkg::short_wait
		+ px_timing_pkg::strob2_ticks + 1;

	logic got, clo_;
	px_state_pkg::state_vec_t enter;
	px_state_pkg::state_vec_t state;
	logic int_start, lip, step_mode, step;
	logic bus_grant, rok_, ren_, stop_;
	logic strob1, strob2, advance, zg, dr_, dw_;
	logic ok, no_mem, alarm, awaria, hlt, ekc_i;
	int errors = 0;
	int resp_mode = resp_ok;	// Bus responder behavior
	int unsigned lcg_state = 23;	// Seed

	state_control u_dut (.*);

	initial begin
		got = 1'b0;
		forever #4 got = ~got;	// 8 ns period
	end

	function automatic px_state_pkg::state_vec_t onehot(input int idx);
		return px_state_pkg::state_vec_t'(1) << idx;
	endfunction

	function int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16;	// Upper bits, better spread
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	task automatic stop_if_hung(input int guard, input int limit, input string what);
		if (guard > limit) begin
			$display("Timeout: no %s within %0d cycles at %0t ns", what, limit, $time);
			$display("Errors counted: %0d", errors);
			$display("** FAIL **");
			$finish;
		end
	endtask

	task automatic to_drive_point();
		@(posedge got);
		#1;	// Inputs change just after the edge
	endtask

	task automatic wait_advance();
		int guard;
		guard = 0;
		do begin
			@(negedge got);
			guard++;
			stop_if_hung(guard, 100, "advance");
		end while (!advance);
	endtask

	task automatic expect_state(input px_state_pkg::state_vec_t exp);
		@(negedge got);	// First cycle after advance
		if (state !== exp)
			report_error($sformatf("state %h, expected %h", state, exp));
	endtask

	task automatic enter_state(input px_state_pkg::state_vec_t vec);
		to_drive_point();
		enter = vec;
		wait_advance();
		expect_state(vec);
	endtask

	task automatic pulse_stop();
		to_drive_point();
		stop_ = 1'b0;
		to_drive_point();
		stop_ = 1'b1;
		@(negedge got);
	endtask

	// Measures one non-bus cycle from first strob1 cycle to advance
	task automatic run_cycle(input int exp_len);
		int guard, len, s1, s2;
		guard = 0;
		while (!strob1) begin
			@(negedge got);
			guard++;
			stop_if_hung(guard, 100, "strob1");
		end
		len = 1;
		s1 = 0;
		s2 = 0;
		while (!advance) begin
			if (strob1) s1++;
			if (strob2) s2++;
			@(negedge got);
			len++;
			stop_if_hung(len, 100, "advance");
		end
		if (len != exp_len)
			report_error($sformatf("cycle took %0d, expected %0d", len, exp_len));
		if (s1 != px_timing_pkg::strob1_ticks)
			report_error($sformatf("strob1 width %0d", s1));
		if (s2 != px_timing_pkg::strob2_ticks)
			report_error($sformatf("strob2 width %0d", s2));
	endtask

	task automatic check_reset_values();
		if (state !== px_state_pkg::reset_state)
			report_error($sformatf("state %h after reset", state));
		if ({strob1, strob2, advance, zg, ok, alarm, no_mem, u_dut.bus_done,
				hlt, awaria, ekc_i} !== '0)
			report_error("control output active after reset");
		if ({dr_, dw_} !== 2'b11)
			report_error("bus driver active after reset");
	endtask

	task automatic nonbus_timing();
		run_cycle(long_len);	// P0 first
		expect_state(onehot(px_state_pkg::st_p2));
		run_cycle(short_len);
		expect_state(onehot(px_state_pkg::st_p2));
		to_drive_point();
		step_mode = 1'b1;
		wait_advance();
		repeat (20) begin
			@(negedge got);
			if (strob1) report_error("strob1 in step mode without step");
		end
		to_drive_point();
		step = 1'b1;
		to_drive_point();
		step = 1'b0;
		run_cycle(short_len);
		expect_state(onehot(px_state_pkg::st_p2));
		to_drive_point();
		step_mode = 1'b0;	// Free running again
	endtask

	task automatic bus_transfer(input logic wr, input px_state_pkg::state_vec_t next);
		int guard;
		to_drive_point();
		bus_grant = 1'b0;	// Bus held by someone else
		enter = next;
		guard = 0;
		do begin
			@(negedge got);
			guard++;
			stop_if_hung(guard, 20, "bus request");
		end while (!zg);
		if (strob1) report_error("zg raised before strob1 ended");
		repeat (6) begin
			if (!dr_ || !dw_) report_error("bus driver active without grant");
			if (!zg) report_error("zg dropped while waiting for grant");
			@(negedge got);
		end
		to_drive_point();
		bus_grant = 1'b1;
		guard = 0;
		do begin
			@(negedge got);
			guard++;
			stop_if_hung(guard, 30, "ok answer");
			if (zg && (wr ? dw_ : dr_)) report_error("driver idle while granted");
			if (wr ? !dr_ : !dw_) report_error("driver of wrong direction active");
			if (alarm || advance) report_error("alarm or advance before answer");
		end while (!ok);
		wait_advance();
		if (alarm || awaria || no_mem) report_error("fault after good answer");
		expect_state(next);
	endtask

	task automatic nomem_answer();
		int guard;
		resp_mode = resp_nomem;
		enter_state(onehot(px_state_pkg::st_wr));
		to_drive_point();
		enter = onehot(px_state_pkg::st_p2);
		guard = 0;
		do begin
			@(negedge got);
			guard++;
			stop_if_hung(guard, 40, "no_mem pulse");
		end while (!no_mem);
		if (!hlt) report_error("hlt not set by no-memory answer");
		@(negedge got);
		if (no_mem) report_error("no_mem longer than one cycle");
		wait_advance();
		expect_state(onehot(px_state_pkg::st_p2));
		resp_mode = resp_ok;
		pulse_stop();
		if (hlt) report_error("hlt not cleared by stop_");
	endtask

	task automatic alarm_timeout();
		int guard, granted_cycles, width;
		logic adv_seen;
		resp_mode = resp_silent;
		enter_state(onehot(px_state_pkg::st_p1));
		to_drive_point();
		bus_grant = 1'b0;	// Ungranted cycles must not count
		enter = onehot(px_state_pkg::st_p2);
		guard = 0;
		do begin
			@(negedge got);
			guard++;
			stop_if_hung(guard, 20, "bus request");
		end while (!zg);
		repeat (6) @(negedge got);
		to_drive_point();
		bus_grant = 1'b1;
		@(negedge got);	// First granted cycle
		granted_cycles = 0;
		while (zg) begin
			granted_cycles++;
			@(negedge got);
			stop_if_hung(granted_cycles, 60, "end of bus request");
		end
		if (granted_cycles != px_timing_pkg::alarm_ticks)
			report_error($sformatf("timeout after %0d granted cycles", granted_cycles));
		guard = 0;
		while (!alarm) begin
			@(negedge got);
			guard++;
			stop_if_hung(guard, 10, "alarm pulse");
		end
		if (!awaria) report_error("awaria not set by timeout");
		width = 0;
		adv_seen = 1'b0;
		while (alarm) begin
			width++;
			adv_seen = adv_seen || advance;	// Cycle may end during alarm
			@(negedge got);
			stop_if_hung(width, 20, "end of alarm");
		end
		if (width != px_timing_pkg::alarm_pulse_ticks)
			report_error($sformatf("alarm width %0d", width));
		if (!adv_seen)
			wait_advance();
		expect_state(onehot(px_state_pkg::st_p2));
		resp_mode = resp_ok;
		pulse_stop();
		if (awaria) report_error("awaria not cleared by stop_");
	endtask

	task automatic interrupt_paths(input logic ret);
		int path[$];
		if (ret)
			path = '{px_state_pkg::st_i1, px_state_pkg::st_i3, px_state_pkg::st_i5};
		else
			path = '{px_state_pkg::st_i1, px_state_pkg::st_i2, px_state_pkg::st_i3,
				px_state_pkg::st_i4, px_state_pkg::st_i5};
		to_drive_point();
		enter = '0;	// Main states idle during the sequence
		int_start = 1'b1;
		lip = ret;
		foreach (path[k]) begin
			wait_advance();
			expect_state(onehot(path[k]));
			if (ekc_i !== (path[k] == px_state_pkg::st_i5))
				report_error($sformatf("ekc_i %b in state bit %0d", ekc_i, path[k]));
			to_drive_point();
			int_start = 1'b0;
			if (path[k] == px_state_pkg::st_i5)
				enter = onehot(px_state_pkg::st_p2);	// Back to main states
		end
		wait_advance();
		expect_state(onehot(px_state_pkg::st_p2));
		if (ekc_i) report_error("ekc_i high after interrupt sequence");
	endtask

	// Bus responder, answers after a random delay
	initial begin : bus_responder
		int delay;
		forever begin
			@(negedge got);
			if (clo_ && (!dr_ || !dw_) && resp_mode != resp_silent) begin
				delay = lcg_next() % 8;
				repeat (delay) @(posedge got);
				to_drive_point();
				if (resp_mode == resp_nomem)
					ren_ = 1'b0;
				else
					rok_ = 1'b0;
				to_drive_point();
				rok_ = 1'b1;	// One-cycle answer
				ren_ = 1'b1;
			end
		end
	end

	initial begin : main_sequence
		clo_ = 1'b0;
		enter = onehot(px_state_pkg::st_p2);
		int_start = 1'b0;
		lip = 1'b0;
		step_mode = 1'b0;
		step = 1'b0;
		bus_grant = 1'b0;
		rok_ = 1'b1;
		ren_ = 1'b1;
		stop_ = 1'b1;
		repeat (10) @(posedge got);
		#1;
		clo_ = 1'b1;
		check_reset_values();
		nonbus_timing();
		enter_state(onehot(px_state_pkg::st_k1));
		bus_transfer(1'b0, onehot(px_state_pkg::st_ww));	// K1 read
		bus_transfer(1'b1, onehot(px_state_pkg::st_p2));	// WW write
		nomem_answer();
		alarm_timeout();
		interrupt_paths(1'b0);
		interrupt_paths(1'b1);
		$display("Tests done, %0d errors", errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
px_state_pkg.sv
px_timing_pkg.sv
one_shot.sv
delay_line.sv
state_register.sv
strobe_gen.sv
interrupt_phase.sv
bus_request.sv
state_control.sv
tb_state_control.sv
